/* Bender.yml */
package:
  name: pipe_core

sources:
  - files:
      - hdl/core_pkg.sv
      - hdl/reg_file.sv
      - hdl/alu.sv
      - hdl/decode_stage.sv
      - hdl/execute_stage.sv
      - hdl/writeback_stage.sv
      - hdl/pipe_core.sv
  - target: test
    files:
      - tests/pipe_core_assert.sv
      - tests/pipe_core_tb.sv

/* hdl/alu.sv */
`default_nettype none

module alu (
    input  wire core_pkg::word_t   a,
    input  wire core_pkg::word_t   b,
    input  wire core_pkg::alu_op_e op,
    output core_pkg::word_t        result,
    output core_pkg::flags_t       flags
);

    logic [16:0] wide;          // result with carry in bit 16
    logic [16:0] shl_wide;
    logic [16:0] shr_wide;      // result in 16:1, last bit out in bit 0
    logic        carry;

    assign shl_wide = {1'b0, a} << b[3:0];
    assign shr_wide = {a, 1'b0} >> b[3:0];

    always_comb begin
        wide  = '0;
        carry = 1'b0;
        case (op)
            core_pkg::alu_add: begin
                wide  = {1'b0, a} + {1'b0, b};
                carry = wide[16];
            end
            core_pkg::alu_sub: begin
                wide  = {1'b0, a} - {1'b0, b};
                carry = wide[16];               // borrow
            end
            core_pkg::alu_and: wide = {1'b0, a & b};
            core_pkg::alu_or:  wide = {1'b0, a | b};
            core_pkg::alu_xor: wide = {1'b0, a ^ b};
            core_pkg::alu_shl: begin
                wide  = {1'b0, shl_wide[15:0]};
                carry = shl_wide[16];           // zero for a shift of 0
            end
            core_pkg::alu_shr: begin
                wide  = {1'b0, shr_wide[16:1]};
                carry = shr_wide[0];
            end
            default: wide = {1'b0, b};          // pass b
        endcase
    end

    assign result = wide[15:0];

    always_comb begin
        flags                      = '0;
        flags[core_pkg::flag_zero]  = (wide[15:0] == '0);
        flags[core_pkg::flag_carry] = carry;
        flags[core_pkg::flag_neg]   = wide[15];
    end

endmodule

`default_nettype wire

/* hdl/core_pkg.sv */
`default_nettype none

package core_pkg;

    typedef logic [15:0] word_t;        // data word
    typedef logic [15:0] instr_t;       // {opcode, rd, rs, rt}
    typedef logic [3:0]  reg_addr_t;    // register index
    typedef logic [2:0]  flags_t;       // {negative, carry, zero}

    localparam int unsigned flag_zero  = 0;
    localparam int unsigned flag_carry = 1;
    localparam int unsigned flag_neg   = 2;

    typedef enum logic [3:0] {
        op_nop = 4'd0,
        op_add, op_sub, op_and, op_or, op_xor,
        op_shl, op_shr,
        op_ldi,                         // rd = {8'h00, imm8}
        op_ld,                          // rd = mem[rs + rt]
        op_st,                          // mem[rs + rt] = rd
        op_hlt
    } opcode_e;

    typedef enum logic [2:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor,
        alu_shl, alu_shr, alu_pass_b
    } alu_op_e;

    typedef struct packed {
        logic mem_rd;
        logic mem_wr;
        logic reg_wr;
    } memc_t;

    typedef struct packed {
        word_t     a;
        word_t     b;
        word_t     sd;                  // store data
        alu_op_e   alu_op;
        memc_t     memc;
        reg_addr_t rd;
        logic      halt;
    } dec_out_t;

    typedef struct packed {
        word_t     result;
        word_t     sd;
        memc_t     memc;
        reg_addr_t rd;
        flags_t    flags;
        logic      halt;
    } ex_out_t;

endpackage

`default_nettype wire

/* hdl/decode_stage.sv */
`default_nettype none

module decode_stage (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                stall,
    input  wire logic                halted,
    input  wire core_pkg::instr_t    instr,
    output core_pkg::reg_addr_t      rd_addr_a,
    output core_pkg::reg_addr_t      rd_addr_b,
    output core_pkg::reg_addr_t      rd_addr_sd,
    input  wire core_pkg::word_t     rd_data_a,
    input  wire core_pkg::word_t     rd_data_b,
    input  wire core_pkg::word_t     rd_data_sd,
    input  wire core_pkg::reg_addr_t ex_rd,
    input  wire logic                ex_reg_wr,
    output core_pkg::dec_out_t       dec_out,
    output logic                     fwd_a,
    output logic                     fwd_b,
    output logic                     fwd_sd
);

    core_pkg::instr_t    instr_q;
    core_pkg::opcode_e   opcode;
    core_pkg::reg_addr_t rd, rs, rt;
    core_pkg::alu_op_e   alu_op;
    core_pkg::memc_t     memc;
    logic                use_a, use_b, use_sd;     // which sources the opcode reads

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            instr_q <= '0;                          // op_nop
        end else if (!(stall || halted)) begin
            instr_q <= instr;
        end
    end

    assign opcode = core_pkg::opcode_e'(instr_q[15:12]);
    assign rd     = instr_q[11:8];
    assign rs     = instr_q[7:4];
    assign rt     = instr_q[3:0];

    assign rd_addr_a  = rs;
    assign rd_addr_b  = rt;
    assign rd_addr_sd = rd;                         // st writes R[rd] to memory

    always_comb begin
        memc   = '0;
        use_a  = 1'b0;
        use_b  = 1'b0;
        use_sd = 1'b0;
        case (opcode)
            core_pkg::op_add, core_pkg::op_sub, core_pkg::op_and, core_pkg::op_or,
            core_pkg::op_xor, core_pkg::op_shl, core_pkg::op_shr: begin
                memc.reg_wr = 1'b1;
                use_a       = 1'b1;
                use_b       = 1'b1;
            end
            core_pkg::op_ldi: begin
                memc.reg_wr = 1'b1;                 // immediate, no sources
            end
            core_pkg::op_ld: begin
                memc.mem_rd = 1'b1;
                memc.reg_wr = 1'b1;
                use_a       = 1'b1;
                use_b       = 1'b1;
            end
            core_pkg::op_st: begin
                memc.mem_wr = 1'b1;
                use_a       = 1'b1;
                use_b       = 1'b1;
                use_sd      = 1'b1;
            end
            default: ;                              // nop, hlt and unused codes
        endcase
    end

    always_comb begin
        case (opcode)
            core_pkg::op_sub: alu_op = core_pkg::alu_sub;
            core_pkg::op_and: alu_op = core_pkg::alu_and;
            core_pkg::op_or:  alu_op = core_pkg::alu_or;
            core_pkg::op_xor: alu_op = core_pkg::alu_xor;
            core_pkg::op_shl: alu_op = core_pkg::alu_shl;
            core_pkg::op_shr: alu_op = core_pkg::alu_shr;
            core_pkg::op_ldi: alu_op = core_pkg::alu_pass_b;
            default:          alu_op = core_pkg::alu_add;   // add, ld/st address
        endcase
    end

    always_comb begin
        dec_out.a      = rd_data_a;
        dec_out.b      = (opcode == core_pkg::op_ldi) ? {8'h00, instr_q[7:0]} : rd_data_b;
        dec_out.sd     = rd_data_sd;
        dec_out.alu_op = alu_op;
        dec_out.memc   = memc;
        dec_out.rd     = rd;
        dec_out.halt   = (opcode == core_pkg::op_hlt);
    end

    // only the instruction one ahead can be unwritten when we read
    assign fwd_a  = use_a  && ex_reg_wr && (rs == ex_rd);
    assign fwd_b  = use_b  && ex_reg_wr && (rt == ex_rd);
    assign fwd_sd = use_sd && ex_reg_wr && (rd == ex_rd);

endmodule

`default_nettype wire

/* hdl/execute_stage.sv */
`default_nettype none

module execute_stage (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               stall,
    input  wire logic               halted,
    input  wire core_pkg::dec_out_t dec_out,
    input  wire logic               fwd_a,
    input  wire logic               fwd_b,
    input  wire logic               fwd_sd,
    input  wire core_pkg::word_t    fwd_data,
    output core_pkg::ex_out_t       ex_out
);

    core_pkg::word_t  op_a;
    core_pkg::word_t  op_b;
    core_pkg::word_t  store_data;
    core_pkg::word_t  alu_result;
    core_pkg::flags_t alu_flags;
    logic             hold;

    assign hold = stall || halted;

    // writeback value replaces a source the register file has not seen yet
    assign op_a       = fwd_a  ? fwd_data : dec_out.a;
    assign op_b       = fwd_b  ? fwd_data : dec_out.b;    // never set for ldi
    assign store_data = fwd_sd ? fwd_data : dec_out.sd;

    alu u_alu (
        .a      (op_a),
        .b      (op_b),
        .op     (dec_out.alu_op),
        .result (alu_result),
        .flags  (alu_flags)
    );

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ex_out <= '0;                               // reads back as a nop
        end else if (!hold) begin
            ex_out.result <= alu_result;
            ex_out.sd     <= store_data;
            ex_out.memc   <= dec_out.memc;
            ex_out.rd     <= dec_out.rd;
            ex_out.flags  <= alu_flags;
            ex_out.halt   <= dec_out.halt;
        end
    end

endmodule

`default_nettype wire

/* hdl/pipe_core.sv */
`default_nettype none

module pipe_core #(
    parameter int unsigned DMEM_AW = 6
) (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             stall,
    input  wire core_pkg::instr_t instr,
    output logic                  wb_en,
    output core_pkg::reg_addr_t   wb_addr,
    output core_pkg::word_t       wb_data,
    output core_pkg::flags_t      wb_flags,
    output logic                  halted
);

    core_pkg::reg_addr_t rd_addr_a, rd_addr_b, rd_addr_sd;
    core_pkg::word_t     rd_data_a, rd_data_b, rd_data_sd;
    core_pkg::dec_out_t  dec_out;
    core_pkg::ex_out_t   ex_out;
    logic                fwd_a, fwd_b, fwd_sd;

    reg_file u_reg_file (
        .clk        (clk),
        .rst        (rst),
        .rd_addr_a  (rd_addr_a),
        .rd_addr_b  (rd_addr_b),
        .rd_addr_sd (rd_addr_sd),
        .rd_data_a  (rd_data_a),
        .rd_data_b  (rd_data_b),
        .rd_data_sd (rd_data_sd),
        .we         (wb_en),
        .wr_addr    (wb_addr),
        .wr_data    (wb_data)
    );

    decode_stage u_decode_stage (
        .clk        (clk),
        .rst        (rst),
        .stall      (stall),
        .halted     (halted),
        .instr      (instr),
        .rd_addr_a  (rd_addr_a),
        .rd_addr_b  (rd_addr_b),
        .rd_addr_sd (rd_addr_sd),
        .rd_data_a  (rd_data_a),
        .rd_data_b  (rd_data_b),
        .rd_data_sd (rd_data_sd),
        .ex_rd      (ex_out.rd),            // instruction one ahead
        .ex_reg_wr  (ex_out.memc.reg_wr),
        .dec_out    (dec_out),
        .fwd_a      (fwd_a),
        .fwd_b      (fwd_b),
        .fwd_sd     (fwd_sd)
    );

    execute_stage u_execute_stage (
        .clk      (clk),
        .rst      (rst),
        .stall    (stall),
        .halted   (halted),
        .dec_out  (dec_out),
        .fwd_a    (fwd_a),
        .fwd_b    (fwd_b),
        .fwd_sd   (fwd_sd),
        .fwd_data (wb_data),                // writeback result of the same cycle
        .ex_out   (ex_out)
    );

    writeback_stage #(
        .DMEM_AW (DMEM_AW)
    ) u_writeback_stage (
        .clk      (clk),
        .rst      (rst),
        .stall    (stall),
        .ex_out   (ex_out),
        .wb_en    (wb_en),
        .wb_addr  (wb_addr),
        .wb_data  (wb_data),
        .wb_flags (wb_flags),
        .halted   (halted)
    );

endmodule

`default_nettype wire

/* hdl/reg_file.sv */
`default_nettype none

module reg_file (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire core_pkg::reg_addr_t rd_addr_a,
    input  wire core_pkg::reg_addr_t rd_addr_b,
    input  wire core_pkg::reg_addr_t rd_addr_sd,
    output core_pkg::word_t          rd_data_a,
    output core_pkg::word_t          rd_data_b,
    output core_pkg::word_t          rd_data_sd,
    input  wire logic                we,
    input  wire core_pkg::reg_addr_t wr_addr,
    input  wire core_pkg::word_t     wr_data
);

    localparam int unsigned num_regs = 16;

    core_pkg::word_t regs [num_regs];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // no write-through, decode reads one cycle after the write edge
    assign rd_data_a  = regs[rd_addr_a];
    assign rd_data_b  = regs[rd_addr_b];
    assign rd_data_sd = regs[rd_addr_sd];  // store data port

endmodule

`default_nettype wire

/* hdl/writeback_stage.sv */
`default_nettype none

module writeback_stage #(
    parameter int unsigned DMEM_AW = 6
) (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              stall,
    input  wire core_pkg::ex_out_t ex_out,
    output logic                   wb_en,
    output core_pkg::reg_addr_t    wb_addr,
    output core_pkg::word_t        wb_data,
    output core_pkg::flags_t       wb_flags,
    output logic                   halted
);

    localparam int unsigned dmem_depth = 2 ** DMEM_AW;

    core_pkg::word_t    dmem [dmem_depth];
    core_pkg::word_t    dmem_rdata;
    logic [DMEM_AW-1:0] dmem_addr;
    logic               commit;                    // this instruction takes effect now

    assign commit    = !stall && !halted;
    assign dmem_addr = ex_out.result[DMEM_AW-1:0];  // alu computed rs + rt
    assign dmem_rdata = dmem[dmem_addr];            // combinational read, no load-use stall

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < dmem_depth; i++) begin
                dmem[i] <= '0;
            end
        end else if (commit && ex_out.memc.mem_wr) begin
            dmem[dmem_addr] <= ex_out.sd;
        end
    end

    // sticky until reset, halt itself does not write anything
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            halted <= 1'b0;
        end else if (ex_out.halt && !stall) begin
            halted <= 1'b1;
        end
    end

    assign wb_en    = ex_out.memc.reg_wr && commit;     // once per instruction
    assign wb_addr  = ex_out.rd;
    assign wb_data  = ex_out.memc.mem_rd ? dmem_rdata : ex_out.result;
    assign wb_flags = ex_out.flags;                     // address flags for ld

endmodule

`default_nettype wire

/* tests/pipe_core_assert.sv */
`default_nettype none

module pipe_core_assert (
    input wire logic clk,
    input wire logic rst,
    input wire logic stall,
    input wire logic wb_en,
    input wire logic halted
);

    timeunit 1ns;
    timeprecision 1ps;

    // a stalled writeback holds its write for a later cycle
    no_write_in_stall: assert property (@(posedge clk) disable iff (rst) stall |-> !wb_en)
        else $error("wb_en high while stall is high");

    halted_sticky: assert property (@(posedge clk) disable iff (rst) halted |=> halted)
        else $error("halted fell without a reset");

    idle_after_reset: assert property (@(posedge clk) $fell(rst) |-> !wb_en && !halted)
        else $error("wb_en or halted high in the cycle after reset");

endmodule

bind pipe_core pipe_core_assert u_pipe_core_assert (
    .clk    (clk),
    .rst    (rst),
    .stall  (stall),
    .wb_en  (wb_en),
    .halted (halted)
);

`default_nettype wire

/* tests/pipe_core_tb.sv */
`default_nettype none

module pipe_core_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int unsigned dmem_aw = 6;
    localparam int unsigned margin  = 50;

    typedef struct packed {
        core_pkg::reg_addr_t addr;
        core_pkg::word_t     data;
        core_pkg::flags_t    flags;
    } wr_exp_t;

    logic                clk = 1'b0;
    logic                rst;
    logic                stall;
    core_pkg::instr_t    instr;
    logic                wb_en;
    logic                halted;
    core_pkg::reg_addr_t wb_addr;
    core_pkg::word_t     wb_data;
    core_pkg::flags_t    wb_flags;

    core_pkg::word_t ref_regs [16];
    core_pkg::word_t ref_mem [2**dmem_aw];
    wr_exp_t         exp_q [$];
    wr_exp_t         got;
    logic            frozen = 1'b0;         // model has issued a halt
    logic            halted_q = 1'b0;
    int              seed = 82;
    int unsigned     cycles = 0;
    int unsigned     limit = margin;        // grows with issued and stalled cycles

    pipe_core #(
        .DMEM_AW (dmem_aw)
    ) u_pipe_core (
        .clk      (clk),
        .rst      (rst),
        .stall    (stall),
        .instr    (instr),
        .wb_en    (wb_en),
        .wb_addr  (wb_addr),
        .wb_data  (wb_data),
        .wb_flags (wb_flags),
        .halted   (halted)
    );

    always #4 clk = ~clk;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "simulation stopped at %0t", $time);
    endtask

    task automatic check_reg_addr(input string name, input core_pkg::reg_addr_t exp,
                                  input core_pkg::reg_addr_t act);
        if (act !== exp)
            fail_run($sformatf("error: %s expected 0x%h got 0x%h", name, exp, act));
    endtask

    task automatic check_word(input string name, input core_pkg::word_t exp,
                              input core_pkg::word_t act);
        if (act !== exp)
            fail_run($sformatf("error: %s expected 0x%h got 0x%h", name, exp, act));
    endtask

    task automatic check_flags(input string name, input core_pkg::flags_t exp,
                               input core_pkg::flags_t act);
        if (act !== exp)
            fail_run($sformatf("error: %s expected 0x%h got 0x%h", name, exp, act));
    endtask

    task automatic expect_level(input string name, input logic exp, input logic act);
        if (act !== exp)
            fail_run($sformatf("error: %s expected 0x%h got 0x%h", name, exp, act));
    endtask

    // outputs are settled by the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            if (halted_q && !halted)
                fail_run("halted fell without a reset");
            if (wb_en && stall)
                fail_run("a register write was reported during a stall");
            if (wb_en) begin
                if (exp_q.size() == 0) begin
                    fail_run("a register write appeared with no instruction pending");
                end else begin
                    got = exp_q.pop_front();
                    check_reg_addr("wb_addr", got.addr, wb_addr);
                    check_word("wb_data", got.data, wb_data);
                    check_flags("wb_flags", got.flags, wb_flags);
                end
            end
        end
        halted_q = rst ? 1'b0 : halted;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit)
            fail_run("the run hung and reached its cycle limit");
    end

    function automatic core_pkg::instr_t enc(input core_pkg::opcode_e op,
            input core_pkg::reg_addr_t rd, input core_pkg::reg_addr_t rs,
            input core_pkg::reg_addr_t rt);
        return {op, rd, rs, rt};
    endfunction

    // present one instruction and predict its write from the ISA rules
    task automatic issue(input core_pkg::instr_t i);
        core_pkg::opcode_e   op;
        core_pkg::reg_addr_t rd;
        core_pkg::word_t     a;
        core_pkg::word_t     b;
        core_pkg::word_t     val;
        core_pkg::word_t     data;
        logic [16:0]         sum;
        logic                carry;
        logic                wr;
        int unsigned         sh;
        wr_exp_t             wr_exp;
        @(posedge clk);
        stall <= 1'b0;
        instr <= i;
        limit += 1;
        op    = core_pkg::opcode_e'(i[15:12]);
        rd    = i[11:8];
        a     = ref_regs[i[7:4]];
        b     = ref_regs[i[3:0]];
        sh    = b[3:0];
        sum   = {1'b0, a} + {1'b0, b};
        val   = sum[15:0];                  // add, and the ld/st address
        carry = 1'b0;
        wr    = !frozen;
        case (op)
            core_pkg::op_add, core_pkg::op_ld:
                carry = sum[16];
            core_pkg::op_sub: begin
                val   = a - b;
                carry = (a < b);            // borrow
            end
            core_pkg::op_and:
                val = a & b;
            core_pkg::op_or:
                val = a | b;
            core_pkg::op_xor:
                val = a ^ b;
            core_pkg::op_shl: begin
                val   = a << sh;
                carry = (sh != 0) && a[16 - sh];
            end
            core_pkg::op_shr: begin
                val   = a >> sh;
                carry = (sh != 0) && a[sh - 1];
            end
            core_pkg::op_ldi:
                val = {8'h00, i[7:0]};
            core_pkg::op_st: begin
                if (!frozen)
                    ref_mem[sum[dmem_aw-1:0]] = ref_regs[rd];
                wr = 1'b0;
            end
            core_pkg::op_hlt: begin
                wr     = 1'b0;
                frozen = 1'b1;
            end
            default:
                wr = 1'b0;
        endcase
        data = (op == core_pkg::op_ld) ? ref_mem[sum[dmem_aw-1:0]] : val;
        if (wr) begin
            ref_regs[rd] = data;
            wr_exp.addr  = rd;
            wr_exp.data  = data;
            wr_exp.flags = {val[15], carry, val == '0};
            exp_q.push_back(wr_exp);
        end
    endtask

    task automatic step_nop();
        @(posedge clk);
        stall <= 1'b0;
        instr <= '0;
    endtask

    task automatic stall_for(input int unsigned n);
        limit += n;
        repeat (n) begin
            @(posedge clk);
            stall <= 1'b1;                  // instr is held
        end
    endtask

    task automatic drain();
        while (exp_q.size() != 0)
            step_nop();
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst   <= 1'b1;
        stall <= 1'b0;
        instr <= '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        exp_q.delete();
        frozen = 1'b0;
        foreach (ref_regs[r])
            ref_regs[r] = '0;
        foreach (ref_mem[m])
            ref_mem[m] = '0;
    endtask

    task automatic reset_then_idle();
        @(negedge clk);
        expect_level("wb_en", 1'b0, wb_en);
        expect_level("halted", 1'b0, halted);
        repeat (6)
            issue('0);
        drain();
    endtask

    task automatic independent_ops();
        logic [7:0] imm;
        repeat (3) begin
            for (core_pkg::reg_addr_t r = 1; r <= 4; r++) begin
                imm = 8'($random(seed));
                issue(enc(core_pkg::op_ldi, r, imm[7:4], imm[3:0]));
            end
            issue(enc(core_pkg::op_add, 4'd5, 4'd1, 4'd2));
            issue(enc(core_pkg::op_sub, 4'd6, 4'd3, 4'd4));
            issue(enc(core_pkg::op_and, 4'd7, 4'd1, 4'd3));
            issue(enc(core_pkg::op_or, 4'd8, 4'd2, 4'd4));
            issue(enc(core_pkg::op_xor, 4'd9, 4'd1, 4'd4));
            issue(enc(core_pkg::op_shl, 4'd10, 4'd2, 4'd3));
            issue(enc(core_pkg::op_shr, 4'd11, 4'd4, 4'd1));
            issue(enc(core_pkg::op_sub, 4'd12, 4'd1, 4'd2));
        end
        drain();
    endtask

    task automatic dependent_forwarding();
        issue(enc(core_pkg::op_ldi, 4'd1, 4'h8, 4'h3));
        issue(enc(core_pkg::op_ldi, 4'd2, 4'hf, 4'hd));
        issue(enc(core_pkg::op_add, 4'd3, 4'd1, 4'd2));    // rt forwarded
        issue(enc(core_pkg::op_sub, 4'd4, 4'd3, 4'd1));    // rs forwarded
        issue(enc(core_pkg::op_xor, 4'd5, 4'd2, 4'd4));    // rt forwarded
        issue(enc(core_pkg::op_add, 4'd6, 4'd5, 4'd5));    // both
        issue(enc(core_pkg::op_shr, 4'd7, 4'd6, 4'd6));
        drain();
    endtask

    task automatic store_then_load();
        issue(enc(core_pkg::op_ldi, 4'd1, 4'h0, 4'hc));
        issue(enc(core_pkg::op_ldi, 4'd2, 4'h1, 4'h7));
        issue(enc(core_pkg::op_ldi, 4'd3, 4'ha, 4'h5));
        issue(enc(core_pkg::op_st, 4'd3, 4'd1, 4'd2));     // store data forwarded
        issue(enc(core_pkg::op_ld, 4'd4, 4'd1, 4'd2));
        issue(enc(core_pkg::op_add, 4'd5, 4'd4, 4'd4));    // load result forwarded
        issue(enc(core_pkg::op_ldi, 4'd6, 4'h3, 4'hc));
        issue('0);
        issue(enc(core_pkg::op_st, 4'd6, 4'd2, 4'd1));
        issue(enc(core_pkg::op_ld, 4'd7, 4'd2, 4'd1));
        drain();
    endtask

    task automatic random_stalls();
        logic [3:0] op_code;
        repeat (40) begin
            op_code = 4'(1 + unsigned'($random(seed)) % 10);  // add up to st
            issue({op_code, 12'($random(seed))});
            if (unsigned'($random(seed)) % 4 == 0)
                stall_for(1 + unsigned'($random(seed)) % 3);
        end
        drain();
    endtask

    task automatic halt_freezes();
        issue(enc(core_pkg::op_ldi, 4'd1, 4'h5, 4'ha));
        issue(enc(core_pkg::op_add, 4'd2, 4'd1, 4'd1));    // ahead of the halt
        issue(enc(core_pkg::op_hlt, 4'd0, 4'd0, 4'd0));
        issue(enc(core_pkg::op_ldi, 4'd3, 4'h7, 4'h7));
        issue(enc(core_pkg::op_add, 4'd4, 4'd2, 4'd2));
        while (!halted)
            step_nop();
        repeat (5)
            issue(enc(core_pkg::op_ldi, 4'd5, 4'h1, 4'h1));
        @(negedge clk);
        expect_level("halted", 1'b1, halted);
        if (exp_q.size() != 0)
            fail_run("writes ahead of the halt never appeared");
        apply_reset();
        @(negedge clk);
        expect_level("halted", 1'b0, halted);
        expect_level("wb_en", 1'b0, wb_en);
    endtask

    initial begin
        rst   = 1'b1;
        stall = 1'b0;
        instr = '0;
        apply_reset();
        reset_then_idle();
        independent_ops();
        dependent_forwarding();
        store_then_load();
        random_stalls();
        halt_freezes();
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
hdl/core_pkg.sv
hdl/reg_file.sv
hdl/alu.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/writeback_stage.sv
hdl/pipe_core.sv
tests/pipe_core_assert.sv
tests/pipe_core_tb.sv
